//--- hdl/board_glue_pkg.sv
// shared widths, bit masks, register codes and bus structs for the board glue and its testbench

package board_glue_pkg;

  // ********************
  // widths
  // ********************

  localparam int GPIO_W   = 64;
  localparam int BD_PAD_W = 21;
  localparam int RF_PAD_W = 24;
  localparam int PAD_W    = RF_PAD_W + BD_PAD_W;
  localparam int REG_W    = 32;

  // gpio bits with no pad, read back from the out word
  // lo covers 31:21, hi covers 50:47 and 63:62
  localparam logic [31:0] LOOP_LO_MASK = 32'hFFE0_0000;
  localparam logic [31:0] LOOP_HI_MASK = 32'hC007_8000;

  // radio control pins taken from the out word
  localparam int ENABLE_BIT = 47;
  localparam int TXNRX_BIT  = 48;

  // ********************
  // register map
  // ********************

  typedef logic [2:0] reg_addr_t;

  localparam reg_addr_t ADDR_OUT_LO = 3'd0;
  localparam reg_addr_t ADDR_OUT_HI = 3'd1;
  localparam reg_addr_t ADDR_TRI_LO = 3'd2;
  localparam reg_addr_t ADDR_TRI_HI = 3'd3;
  localparam reg_addr_t ADDR_IN_LO  = 3'd4;
  localparam reg_addr_t ADDR_IN_HI  = 3'd5;

  // ********************
  // bus structs
  // ********************

  // shared spi master outputs, csn[0] transceiver, csn[1] clock chip
  typedef struct packed {
    logic       sclk;
    logic       mosi;
    logic [1:0] csn;
  } spi_master_t;

  typedef struct packed {
    logic sclk;
    logic mosi;
    logic csn;
  } spi_dev_t;

  // tris bit set means the pad is not driven
  typedef struct packed {
    logic [GPIO_W-1:0] out;
    logic [GPIO_W-1:0] tris;
  } gpio_ctl_t;

  typedef struct packed {
    logic             wr;
    reg_addr_t        addr;
    logic [REG_W-1:0] wdata;
  } reg_cmd_t;

  // radio pads in the upper 24 bits, board pads in the lower 21
  typedef struct packed {
    logic [PAD_W-1:0] out;
    logic [PAD_W-1:0] oe;
  } pad_bus_t;

endpackage

//--- hdl/pin_sync.sv
// two-flop synchronizer for asynchronous board pins, any packed payload type
`timescale 1ns/100ps

module pin_sync #(
  parameter type payload_t = logic
) (
  input  logic     sys_cpu_clk,
  input  logic     rf_peak_rst_0,
  input  payload_t d_i,
  output payload_t q_o
);

  payload_t meta_r;

  // both stages idle high, the rest level of active-low pins
  always_ff @(posedge sys_cpu_clk) begin
    if (rf_peak_rst_0) begin
      meta_r <= '1;
      q_o    <= '1;
    end else begin
      meta_r <= d_i;
      q_o    <= meta_r;
    end
  end

  a_q_known: assert property (@(posedge sys_cpu_clk) disable iff (rf_peak_rst_0)
    !$isunknown(q_o))
    else $error("pin_sync output has unknown bits");

endmodule

//--- hdl/rf_peak_guard.sv
// radio input protection that drives a toggling reset while the peak detector reports overload
`timescale 1ns/100ps

module rf_peak_guard (
  input  logic sys_cpu_clk,
  input  logic rf_peak_rst_0,
  input  logic peak_det_n_i,
  output logic peak_rst_o
);

  logic peak_det_n_s;
  logic peak_det_n_d;
  logic window_s;
  logic window_d;
  logic window_open_s;
  logic window_close_s;
  logic toggle_en;
  logic peak_rst_r;

  pin_sync #(
    .payload_t (logic)
  ) i_peak_sync (
    .sys_cpu_clk   (sys_cpu_clk),
    .rf_peak_rst_0 (rf_peak_rst_0),
    .d_i           (peak_det_n_i),
    .q_o           (peak_det_n_s)
  );

  // ********************
  // overload window
  // ********************

  // open while either of the last two samples is low
  assign window_s       = ~(peak_det_n_d & peak_det_n_s);
  assign window_open_s  = window_s & ~window_d;
  assign window_close_s = ~window_s & window_d;

  always_ff @(posedge sys_cpu_clk) begin
    if (rf_peak_rst_0) begin
      peak_det_n_d <= 1'b1;
      window_d     <= 1'b0;
      toggle_en    <= 1'b0;
      peak_rst_r   <= 1'b0;
    end else begin
      peak_det_n_d <= peak_det_n_s;
      window_d     <= window_s;
      if (window_open_s) begin
        toggle_en <= 1'b1;
      end else if (window_close_s) begin
        toggle_en <= 1'b0;
      end
      // alternates 1 and 0 and is held low once disabled
      peak_rst_r <= ~peak_rst_r & toggle_en;
    end
  end

  assign peak_rst_o = peak_rst_r;

  a_no_double_high: assert property (@(posedge sys_cpu_clk) disable iff (rf_peak_rst_0)
    peak_rst_o |=> !peak_rst_o)
    else $error("peak reset high on two consecutive cycles");

endmodule

//--- hdl/spi_cs_fanout.sv
// shares one spi master between the transceiver and the clock chip
`timescale 1ns/100ps

module spi_cs_fanout
  import board_glue_pkg::*;
(
  input  spi_master_t master_i,
  output logic        miso_o,
  output spi_dev_t    dev0_o,
  output spi_dev_t    dev1_o,
  input  logic        dev0_miso_i,
  input  logic        dev1_miso_i
);

  logic miso_dev0_s;
  logic miso_dev1_s;

  // ********************
  // select routing
  // ********************

  // device 0 is the transceiver, device 1 the clock chip
  assign dev0_o = '{
    sclk: master_i.sclk,
    mosi: master_i.mosi,
    csn:  master_i.csn[0]
  };

  assign dev1_o = '{
    sclk: master_i.sclk,
    mosi: master_i.mosi,
    csn:  master_i.csn[1]
  };

  // only a selected device may answer
  assign miso_dev0_s = ~master_i.csn[0] & dev0_miso_i;
  assign miso_dev1_s = ~master_i.csn[1] & dev1_miso_i;
  assign miso_o      = miso_dev0_s | miso_dev1_s;

  // checked on the spi clock, one device per transfer
  a_one_select: assert property (@(posedge master_i.sclk)
    master_i.csn != 2'b00)
    else $error("both spi devices selected at once");

endmodule

//--- hdl/gpio_pad_map.sv
// bit map between the 64-bit gpio word and the board and radio pads, resolves the input word
`timescale 1ns/100ps

module gpio_pad_map
  import board_glue_pkg::*;
(
  input  gpio_ctl_t         ctl_i,
  output pad_bus_t          pad_o,
  input  logic [PAD_W-1:0]  pad_in_i,
  output logic [GPIO_W-1:0] gpio_in_o
);

  logic [PAD_W-1:0]  pad_out_s;
  logic [PAD_W-1:0]  pad_tri_s;
  logic [PAD_W-1:0]  pad_res_s;
  logic [GPIO_W-1:0] loop_s;

  // ********************
  // pad gather
  // ********************

  // radio group 60:55, 53:51, 46:32 above board group 20:0
  assign pad_out_s = {
    ctl_i.out[60:55],
    ctl_i.out[53:51],
    ctl_i.out[46:32],
    ctl_i.out[BD_PAD_W-1:0]
  };

  assign pad_tri_s = {
    ctl_i.tris[60:55],
    ctl_i.tris[53:51],
    ctl_i.tris[46:32],
    ctl_i.tris[BD_PAD_W-1:0]
  };

  assign pad_o = '{out: pad_out_s, oe: ~pad_tri_s};

  // tristated pad reads the pin, driven pad reads its own out bit
  assign pad_res_s = (pad_in_i & pad_tri_s) | (pad_out_s & ~pad_tri_s);

  // no-pad bits loop back, 54 and 61 fall out as zero
  assign loop_s = ctl_i.out & {LOOP_HI_MASK, LOOP_LO_MASK};

  // ********************
  // input word scatter
  // ********************

  always_comb begin
    gpio_in_o                 = loop_s;
    gpio_in_o[BD_PAD_W-1:0]   = pad_res_s[BD_PAD_W-1:0];
    gpio_in_o[46:32]          = pad_res_s[35:21];
    gpio_in_o[53:51]          = pad_res_s[38:36];
    gpio_in_o[60:55]          = pad_res_s[44:39];
  end

endmodule

//--- hdl/gpio_reg_port.sv
// host register port with four-phase req/ack that holds the gpio out and tristate words
`timescale 1ns/100ps

module gpio_reg_port
  import board_glue_pkg::*;
(
  input  logic              sys_cpu_clk,
  input  logic              rf_peak_rst_0,
  input  logic              req_i,
  input  reg_cmd_t          cmd_i,
  output logic              ack_o,
  output logic [REG_W-1:0]  rdata_o,
  input  logic [GPIO_W-1:0] gpio_in_i,
  output gpio_ctl_t         ctl_o
);

  typedef enum logic {
    ST_IDLE,
    ST_ACK
  } hs_state_t;

  hs_state_t         state_r;
  logic              access_s;
  logic [GPIO_W-1:0] out_r;
  logic [GPIO_W-1:0] tri_r;
  logic [REG_W-1:0]  rdata_s;
  logic [REG_W-1:0]  rdata_r;

  // one access per request while ack is still low
  assign access_s = (state_r == ST_IDLE) & req_i;

  // ********************
  // handshake FSM
  // ********************

  always_ff @(posedge sys_cpu_clk) begin
    if (rf_peak_rst_0) begin
      state_r <= ST_IDLE;
    end else begin
      case (state_r)
        ST_IDLE: if (req_i) state_r <= ST_ACK;
        ST_ACK:  if (!req_i) state_r <= ST_IDLE;
        default: state_r <= ST_IDLE;
      endcase
    end
  end

  assign ack_o = (state_r == ST_ACK);

  // ********************
  // register file
  // ********************

  // tristate word resets to all ones so no pad is driven
  always_ff @(posedge sys_cpu_clk) begin
    if (rf_peak_rst_0) begin
      out_r <= '0;
      tri_r <= '1;
    end else if (access_s && cmd_i.wr) begin
      case (cmd_i.addr)
        ADDR_OUT_LO: out_r[REG_W-1:0]      <= cmd_i.wdata;
        ADDR_OUT_HI: out_r[GPIO_W-1:REG_W] <= cmd_i.wdata;
        ADDR_TRI_LO: tri_r[REG_W-1:0]      <= cmd_i.wdata;
        ADDR_TRI_HI: tri_r[GPIO_W-1:REG_W] <= cmd_i.wdata;
        // input word halves are read-only
        default: ;
      endcase
    end
  end

  always_comb begin
    case (cmd_i.addr)
      ADDR_OUT_LO: rdata_s = out_r[REG_W-1:0];
      ADDR_OUT_HI: rdata_s = out_r[GPIO_W-1:REG_W];
      ADDR_TRI_LO: rdata_s = tri_r[REG_W-1:0];
      ADDR_TRI_HI: rdata_s = tri_r[GPIO_W-1:REG_W];
      ADDR_IN_LO:  rdata_s = gpio_in_i[REG_W-1:0];
      ADDR_IN_HI:  rdata_s = gpio_in_i[GPIO_W-1:REG_W];
      default:     rdata_s = '0;
    endcase
  end

  // read data is captured with the access and held until the next read
  always_ff @(posedge sys_cpu_clk) begin
    if (access_s && !cmd_i.wr) begin
      rdata_r <= rdata_s;
    end
  end

  assign rdata_o = rdata_r;
  assign ctl_o   = '{out: out_r, tris: tri_r};

  a_ack_fall: assert property (@(posedge sys_cpu_clk) disable iff (rf_peak_rst_0)
    $fell(ack_o) |-> $past(!req_i))
    else $error("ack dropped while request still high");

  a_cmd_stable: assert property (@(posedge sys_cpu_clk) disable iff (rf_peak_rst_0)
    ($past(req_i && !ack_o) && req_i) |-> $stable(cmd_i))
    else $error("host command changed before acknowledge");

endmodule

//--- hdl/board_glue_top.sv
// board glue top level, connects spi sharing, gpio pads, host port and radio protection
`timescale 1ns/100ps

module board_glue_top
  import board_glue_pkg::*;
(
  input  logic              sys_cpu_clk,
  input  logic              rf_peak_rst_0,
  // host register port
  input  logic              req_i,
  input  reg_cmd_t          cmd_i,
  output logic              ack_o,
  output logic [REG_W-1:0]  rdata_o,
  // shared spi
  input  spi_master_t       spi_master_i,
  output logic              spi_miso_o,
  output spi_dev_t          spi_dev0_o,
  output spi_dev_t          spi_dev1_o,
  input  logic              dev0_miso_i,
  input  logic              dev1_miso_i,
  // radio protection
  input  logic              peak_det_n_i,
  output logic              peak_rst_o,
  // pads
  output pad_bus_t          pad_o,
  input  logic [PAD_W-1:0]  pad_in_i,
  output logic              enable_o,
  output logic              txnrx_o
);

  gpio_ctl_t         gpio_ctl_s;
  logic [GPIO_W-1:0] gpio_in_s;
  logic [PAD_W-1:0]  pad_in_s;

  // ********************
  // gpio path
  // ********************

  gpio_reg_port i_reg_port (
    .sys_cpu_clk   (sys_cpu_clk),
    .rf_peak_rst_0 (rf_peak_rst_0),
    .req_i         (req_i),
    .cmd_i         (cmd_i),
    .ack_o         (ack_o),
    .rdata_o       (rdata_o),
    .gpio_in_i     (gpio_in_s),
    .ctl_o         (gpio_ctl_s)
  );

  // pad inputs are asynchronous to the cpu clock
  pin_sync #(
    .payload_t (logic [PAD_W-1:0])
  ) i_pad_sync (
    .sys_cpu_clk   (sys_cpu_clk),
    .rf_peak_rst_0 (rf_peak_rst_0),
    .d_i           (pad_in_i),
    .q_o           (pad_in_s)
  );

  gpio_pad_map i_pad_map (
    .ctl_i     (gpio_ctl_s),
    .pad_o     (pad_o),
    .pad_in_i  (pad_in_s),
    .gpio_in_o (gpio_in_s)
  );

  // radio control straight from the out word, no pad direction
  assign enable_o = gpio_ctl_s.out[ENABLE_BIT];
  assign txnrx_o  = gpio_ctl_s.out[TXNRX_BIT];

  // ********************
  // spi and protection
  // ********************

  spi_cs_fanout i_spi_fanout (
    .master_i    (spi_master_i),
    .miso_o      (spi_miso_o),
    .dev0_o      (spi_dev0_o),
    .dev1_o      (spi_dev1_o),
    .dev0_miso_i (dev0_miso_i),
    .dev1_miso_i (dev1_miso_i)
  );

  rf_peak_guard i_peak_guard (
    .sys_cpu_clk   (sys_cpu_clk),
    .rf_peak_rst_0 (rf_peak_rst_0),
    .peak_det_n_i  (peak_det_n_i),
    .peak_rst_o    (peak_rst_o)
  );

  // first cycle out of reset leaves every pad and radio pin quiet
  a_reset_quiet: assert property (@(posedge sys_cpu_clk)
    $past(rf_peak_rst_0) |-> (pad_o.oe == '0) && !enable_o && !txnrx_o && !peak_rst_o)
    else $error("outputs active right after reset");

endmodule

//--- verif/tb_board_glue.sv
// self-checking testbench for board_glue_top that replays a table of host, pad, spi and peak steps
`timescale 1ns/100ps

module tb_board_glue
  import board_glue_pkg::*;
();

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_PAD, OP_SPI, OP_PEAK} op_t;

  // spi steps pack {dev1 miso, dev0 miso, sclk, mosi, csn} into data
  typedef struct packed {
    op_t              op;
    reg_addr_t        addr;
    logic [REG_W-1:0] data;
    logic [PAD_W-1:0] pad;
    logic [REG_W-1:0] exp;
  } entry_t;

  logic              sys_cpu_clk;
  logic              rf_peak_rst_0;
  logic              req_i;
  reg_cmd_t          cmd_i;
  logic              ack_o;
  logic [REG_W-1:0]  rdata_o;
  spi_master_t       spi_master_i;
  logic              spi_miso_o;
  spi_dev_t          spi_dev0_o;
  spi_dev_t          spi_dev1_o;
  logic              dev0_miso_i;
  logic              dev1_miso_i;
  logic              peak_det_n_i;
  logic              peak_rst_o;
  pad_bus_t          pad_o;
  logic [PAD_W-1:0]  pad_in_i;
  logic              enable_o;
  logic              txnrx_o;

  entry_t            tbl_q[$];
  string             name_q[$];
  logic [GPIO_W-1:0] m_out;
  logic [GPIO_W-1:0] m_tri;
  logic [PAD_W-1:0]  m_pad;
  logic [31:0]       rnd;
  int                err_cnt;
  int                cycle_cnt;
  int                cycle_limit;

  board_glue_top UUT (.*);

  always #4 sys_cpu_clk = ~sys_cpu_clk;

  always @(posedge sys_cpu_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout, no progress after %0d cycles", cycle_cnt);
      stop_on_error();
    end
  end

  // ********************
  // reference model
  // ********************

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rnd = xorshift(rnd);
    return rnd;
  endfunction

  function automatic bit is_pad(int b);
    return (b <= 20) || (b >= 32 && b <= 46) || (b >= 51 && b <= 53) || (b >= 55 && b <= 60);
  endfunction

  function automatic bit is_loop(int b);
    return (b >= 21 && b <= 31) || (b >= 47 && b <= 50) || (b >= 62);
  endfunction

  // pads numbered upward from gpio bit 0
  function automatic logic [PAD_W-1:0] gather_pads(logic [GPIO_W-1:0] w);
    logic [GPIO_W-1:0] ww;
    logic [PAD_W-1:0]  r;
    ww = w;
    r  = '0;
    for (int b = 0; b < GPIO_W; b++) begin
      if (is_pad(b)) r = {ww[0], r[PAD_W-1:1]};
      ww = ww >> 1;
    end
    return r;
  endfunction

  function automatic logic [GPIO_W-1:0] resolve_word(logic [GPIO_W-1:0] o,
                                                     logic [GPIO_W-1:0] t,
                                                     logic [PAD_W-1:0] p);
    logic [GPIO_W-1:0] oo;
    logic [GPIO_W-1:0] tt;
    logic [GPIO_W-1:0] r;
    logic [PAD_W-1:0]  pp;
    logic              bitv;
    oo = o;
    tt = t;
    pp = p;
    r  = '0;
    for (int b = 0; b < GPIO_W; b++) begin
      if (is_pad(b)) begin
        bitv = tt[0] ? pp[0] : oo[0];
        pp   = pp >> 1;
      end else if (is_loop(b)) begin
        bitv = oo[0];
      end else begin
        bitv = 1'b0;
      end
      r  = {bitv, r[GPIO_W-1:1]};
      oo = oo >> 1;
      tt = tt >> 1;
    end
    return r;
  endfunction

  task automatic model_write(reg_addr_t addr, logic [31:0] data);
    case (addr)
      ADDR_OUT_LO: m_out[31:0]  = data;
      ADDR_OUT_HI: m_out[63:32] = data;
      ADDR_TRI_LO: m_tri[31:0]  = data;
      ADDR_TRI_HI: m_tri[63:32] = data;
      default: ;
    endcase
  endtask

  function automatic logic [31:0] model_read(reg_addr_t addr);
    logic [GPIO_W-1:0] in_w;
    in_w = resolve_word(m_out, m_tri, m_pad);
    case (addr)
      ADDR_OUT_LO: return m_out[31:0];
      ADDR_OUT_HI: return m_out[63:32];
      ADDR_TRI_LO: return m_tri[31:0];
      ADDR_TRI_HI: return m_tri[63:32];
      ADDR_IN_LO:  return in_w[31:0];
      ADDR_IN_HI:  return in_w[63:32];
      default:     return 32'h0;
    endcase
  endfunction

  // ********************
  // stimulus table
  // ********************

  task automatic add_entry(string name, op_t op, reg_addr_t addr, logic [31:0] data,
                           logic [PAD_W-1:0] pad, logic [31:0] exp);
    tbl_q.push_back('{op: op, addr: addr, data: data, pad: pad, exp: exp});
    name_q.push_back(name);
  endtask

  task automatic add_write(string name, reg_addr_t addr, logic [31:0] data);
    model_write(addr, data);
    add_entry(name, OP_WR, addr, data, '0, '0);
  endtask

  task automatic add_read(string name, reg_addr_t addr);
    add_entry(name, OP_RD, addr, '0, '0, model_read(addr));
  endtask

  // drv is {sclk, mosi, csn} and miso is {dev1, dev0}
  task automatic add_spi(string name, logic [3:0] drv, logic [1:0] miso);
    logic [2:0] d0;
    logic [2:0] d1;
    logic       mi;
    d0 = {drv[3], drv[2], drv[0]};
    d1 = {drv[3], drv[2], drv[1]};
    mi = (!drv[0] && miso[0]) || (!drv[1] && miso[1]);
    add_entry(name, OP_SPI, '0, {26'd0, miso, drv}, '0, {25'd0, mi, d1, d0});
  endtask

  task automatic build_table();
    logic [GPIO_W-1:0] pv;
    add_write("out lo write", ADDR_OUT_LO, next_rand());
    add_write("out hi write", ADDR_OUT_HI, next_rand());
    add_write("tri lo write", ADDR_TRI_LO, next_rand());
    add_write("tri hi write", ADDR_TRI_HI, next_rand());
    add_read("out lo read", ADDR_OUT_LO);
    add_read("out hi read", ADDR_OUT_HI);
    add_read("tri lo read", ADDR_TRI_LO);
    add_read("tri hi read", ADDR_TRI_HI);
    add_write("in lo write", ADDR_IN_LO, next_rand());
    add_write("in hi write", ADDR_IN_HI, next_rand());
    add_write("unmapped write", 3'd6, next_rand());
    add_read("out lo after ro", ADDR_OUT_LO);
    add_read("in lo after write", ADDR_IN_LO);
    add_read("in hi after write", ADDR_IN_HI);
    add_read("unmapped 6", 3'd6);
    add_read("unmapped 7", 3'd7);
    // all pads as inputs, all driven, then two mixed rounds
    for (int k = 0; k < 4; k++) begin
      add_write($sformatf("pad %0d out lo", k), ADDR_OUT_LO, next_rand());
      add_write($sformatf("pad %0d out hi", k), ADDR_OUT_HI, next_rand());
      add_write($sformatf("pad %0d tri lo", k), ADDR_TRI_LO,
                (k == 0) ? 32'hFFFF_FFFF : (k == 1) ? 32'h0 : next_rand());
      add_write($sformatf("pad %0d tri hi", k), ADDR_TRI_HI,
                (k == 0) ? 32'hFFFF_FFFF : (k == 1) ? 32'h0 : next_rand());
      pv    = {next_rand(), next_rand()};
      m_pad = pv[PAD_W-1:0];
      add_entry($sformatf("pad %0d drive", k), OP_PAD, '0, '0, m_pad, '0);
      add_read($sformatf("pad %0d in lo", k), ADDR_IN_LO);
      add_read($sformatf("pad %0d in hi", k), ADDR_IN_HI);
    end
    add_spi("spi idle", 4'b0011, 2'b11);
    add_spi("spi dev0 miso hi", 4'b1010, 2'b11);
    add_spi("spi dev0 miso lo", 4'b0110, 2'b10);
    add_spi("spi dev1 miso hi", 4'b1101, 2'b10);
    add_spi("spi dev1 miso lo", 4'b0001, 2'b01);
    add_spi("spi back idle", 4'b1111, 2'b11);
    add_entry("peak pulse", OP_PEAK, '0, 32'd16, '0, '0);
    add_write("enable and txnrx", ADDR_OUT_HI, 32'h0001_8000);
    add_write("enable only", ADDR_OUT_HI, 32'h0000_8000);
    add_write("txnrx only", ADDR_OUT_HI, 32'h0001_0000);
    add_write("radio ctl clear", ADDR_OUT_HI, 32'h0);
  endtask

  // ********************
  // drivers and checks
  // ********************

  task automatic stop_on_error();
    $display("Some tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_val(string name, logic [63:0] exp, logic [63:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("FAILED %s expected %h actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  // every action lands 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge sys_cpu_clk);
    #1;
  endtask

  task automatic wait_ack(logic level);
    do begin
      next_cycle();
    end while (ack_o !== level);
  endtask

  task automatic do_write(reg_addr_t addr, logic [31:0] data);
    cmd_i = '{wr: 1'b1, addr: addr, wdata: data};
    req_i = 1'b1;
    wait_ack(1'b1);
    req_i = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic do_read(reg_addr_t addr, output logic [31:0] data);
    cmd_i = '{wr: 1'b0, addr: addr, wdata: '0};
    req_i = 1'b1;
    wait_ack(1'b1);
    data  = rdata_o;
    req_i = 1'b0;
    wait_ack(1'b0);
  endtask

  // rise within 6 cycles, alternate while low, quiet within 6 after release
  task automatic run_peak(string name, int hold);
    logic seen;
    logic exp_rst;
    int   i;
    seen = 1'b0;
    peak_det_n_i = 1'b0;
    for (i = 0; i < 6 && !seen; i++) begin
      next_cycle();
      seen = peak_rst_o;
    end
    check_val({name, " rise"}, 64'd1, 64'(seen));
    exp_rst = 1'b1;
    for (i = 0; i < hold; i++) begin
      exp_rst = ~exp_rst;
      next_cycle();
      check_val({name, " toggle"}, 64'(exp_rst), 64'(peak_rst_o));
    end
    peak_det_n_i = 1'b1;
    repeat (5) next_cycle();
    for (i = 0; i < 10; i++) begin
      next_cycle();
      check_val({name, " quiet"}, 64'd0, 64'(peak_rst_o));
    end
  endtask

  task automatic apply_entry(entry_t e, string name);
    logic [31:0] rd;
    case (e.op)
      OP_WR: begin
        do_write(e.addr, e.data);
        model_write(e.addr, e.data);
        check_val({name, " pad out"}, 64'(gather_pads(m_out)), 64'(pad_o.out));
        check_val({name, " pad oe"}, 64'(gather_pads(~m_tri)), 64'(pad_o.oe));
        check_val({name, " radio ctl"}, 64'({m_out[TXNRX_BIT], m_out[ENABLE_BIT]}),
                  64'({txnrx_o, enable_o}));
      end
      OP_RD: begin
        do_read(e.addr, rd);
        check_val(name, 64'(e.exp), 64'(rd));
      end
      OP_PAD: begin
        pad_in_i = e.pad;
        repeat (3) next_cycle();
      end
      OP_SPI: begin
        spi_master_i = spi_master_t'(e.data[3:0]);
        dev0_miso_i  = e.data[4];
        dev1_miso_i  = e.data[5];
        next_cycle();
        check_val(name, 64'(e.exp), 64'({spi_miso_o, spi_dev1_o, spi_dev0_o}));
      end
      default: run_peak(name, int'(e.data));
    endcase
  endtask

  task automatic check_reset();
    check_val("reset ack", 64'd0, 64'(ack_o));
    check_val("reset peak rst", 64'd0, 64'(peak_rst_o));
    check_val("reset radio ctl", 64'd0, 64'({txnrx_o, enable_o}));
    check_val("reset selects", 64'd3, 64'({spi_dev1_o.csn, spi_dev0_o.csn}));
    check_val("reset pad oe", 64'd0, 64'(pad_o.oe));
  endtask

  initial begin
    sys_cpu_clk   = 1'b0;
    rf_peak_rst_0 = 1'b1;
    req_i         = 1'b0;
    cmd_i         = '0;
    spi_master_i  = '{sclk: 1'b0, mosi: 1'b0, csn: 2'b11};
    dev0_miso_i   = 1'b0;
    dev1_miso_i   = 1'b0;
    peak_det_n_i  = 1'b1;
    pad_in_i      = '0;
    err_cnt       = 0;
    cycle_cnt     = 0;
    rnd           = 32'h4839;
    m_out         = '0;
    m_tri         = '1;
    m_pad         = '0;
    build_table();
    cycle_limit = tbl_q.size() * 40;
    // model back to the reset state for the replay
    m_out = '0;
    m_tri = '1;
    repeat (3) @(posedge sys_cpu_clk);
    #1;
    rf_peak_rst_0 = 1'b0;
    check_reset();
    foreach (tbl_q[i]) apply_entry(tbl_q[i], name_q[i]);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- tb.f
hdl/board_glue_pkg.sv
hdl/pin_sync.sv
hdl/rf_peak_guard.sv
hdl/spi_cs_fanout.sv
hdl/gpio_pad_map.sv
hdl/gpio_reg_port.sv
hdl/board_glue_top.sv
verif/tb_board_glue.sv

//--- Makefile
# Verilator build and run of the board glue testbench

VERILATOR ?= verilator
TOP       ?= tb_board_glue
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
